/* hw/host_mem_pkg.sv */
/* Sizes and limits shared by the host memory read adapter and its testbench.
   Modules import it inside their body and use scoped names in their port lists. */

package host_mem_pkg;

    // all addresses count lines and never bytes
    localparam int ADDR_W = 32;

    // one line of read data
    localparam int DATA_W = 32;

    // client read ID carried back on the r channel
    localparam int ID_W = 4;

    // length fields hold the number of lines minus one
    localparam int LEN_W = 4;

    // the number of reorder buffer slots is also the total number of read credits
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W = 4;

    // host requests are limited to this many lines
    localparam int MAX_PIECE_LINES = 4;

    // a host request must not cross a page of this many lines
    localparam int PAGE_LINES = 16;

    // free-slot counter must reach ROB_DEPTH, so it is one bit wider than a tag
    localparam int CNT_W = 5;

endpackage

/* hw/burst_splitter.sv */
/* Cuts client read bursts into host requests of at most MAX_PIECE_LINES lines
   that never cross a page. Holds one burst at a time and emits its pieces in order. */

`timescale 1ns/100ps

module burst_splitter
(
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              ar_valid,
    output logic                              ar_ready,
    input  logic [host_mem_pkg::ADDR_W-1:0]   ar_addr,
    input  logic [host_mem_pkg::LEN_W-1:0]    ar_len,
    input  logic [host_mem_pkg::ID_W-1:0]     ar_id,

    output logic                              pc_valid,
    input  logic                              pc_ready,
    output logic [host_mem_pkg::ADDR_W-1:0]   pc_addr,
    output logic [host_mem_pkg::LEN_W-1:0]    pc_len,
    output logic [host_mem_pkg::ID_W-1:0]     pc_id,
    output logic                              pc_last
);

    import host_mem_pkg::*;

    // set while a burst is being cut into pieces
    logic                busy;

    // address and remaining line count of the current burst
    logic [ADDR_W-1:0]   cur_addr;
    logic [LEN_W:0]      rem_lines;
    logic [ID_W-1:0]     cur_id;

    // line counts are one bit wider than a length field so 16 fits
    logic [LEN_W:0]      page_off;
    logic [LEN_W:0]      page_left;
    logic [LEN_W:0]      piece_lines;

    assign ar_ready = !busy;
    assign pc_valid = busy;

    // lines left before the next page boundary run from 1 up to PAGE_LINES
    assign page_off = (LEN_W+1)'(cur_addr % PAGE_LINES);
    assign page_left = (LEN_W+1)'(PAGE_LINES) - page_off;

    // the piece is the smallest of the host limit, the burst remainder and the page remainder
    always_comb
    begin
        piece_lines = (LEN_W+1)'(MAX_PIECE_LINES);
        if (rem_lines < piece_lines)
            piece_lines = rem_lines;
        if (page_left < piece_lines)
            piece_lines = page_left;
    end

    assign pc_addr = cur_addr;
    assign pc_len = LEN_W'(piece_lines - (LEN_W+1)'(1));
    assign pc_id = cur_id;

    // this piece uses up everything that was left of the burst
    assign pc_last = (piece_lines == rem_lines);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
        end
        else if (ar_valid && ar_ready)
        begin
            busy <= 1'b1;
        end
        else if (pc_valid && pc_ready && pc_last)
        begin
            // the final piece was taken so the next burst can be accepted
            busy <= 1'b0;
        end
    end

    // position and ID of the burst being cut
    always_ff @(posedge clk)
    begin
        if (ar_valid && ar_ready)
        begin
            cur_addr <= ar_addr;
            rem_lines <= (LEN_W+1)'(ar_len) + (LEN_W+1)'(1);
            cur_id <= ar_id;
        end
        else if (pc_valid && pc_ready)
        begin
            cur_addr <= cur_addr + ADDR_W'(piece_lines);
            rem_lines <= rem_lines - piece_lines;
        end
    end

endmodule

/* hw/rob_slot_alloc.sv */
/* Reserves reorder buffer slots as credits for each piece and issues it as a host
   request tagged with its first slot. Strobes the allocation notice on each transfer. */

`timescale 1ns/100ps

module rob_slot_alloc
(
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              pc_valid,
    output logic                              pc_ready,
    input  logic [host_mem_pkg::ADDR_W-1:0]   pc_addr,
    input  logic [host_mem_pkg::LEN_W-1:0]    pc_len,
    input  logic [host_mem_pkg::ID_W-1:0]     pc_id,
    input  logic                              pc_last,

    output logic                              mem_req_valid,
    input  logic                              mem_req_ready,
    output logic [host_mem_pkg::ADDR_W-1:0]   mem_req_addr,
    output logic [host_mem_pkg::LEN_W-1:0]    mem_req_len,
    output logic [host_mem_pkg::TAG_W-1:0]    mem_req_tag,

    output logic                              alloc_valid,
    output logic [host_mem_pkg::TAG_W-1:0]    alloc_tag,
    output logic [host_mem_pkg::LEN_W-1:0]    alloc_len,
    output logic [host_mem_pkg::ID_W-1:0]     alloc_id,
    output logic                              alloc_last,

    input  logic                              slot_free
);

    import host_mem_pkg::*;

    // next slot to hand out since slots are used in strict ring order
    logic [TAG_W-1:0]    alloc_ptr;

    // slots neither reserved nor holding an unretired line
    logic [CNT_W-1:0]    free_cnt;

    // registered piece waiting for the host
    logic [ID_W-1:0]     req_id;
    logic                req_last;

    logic [CNT_W-1:0]    pc_lines;
    logic                pc_take;
    logic                req_take;

    assign pc_lines = CNT_W'(pc_len) + CNT_W'(1);

    // the credit check lives only here and needs the whole piece to fit in the free slots.
    // the output register must also be empty or draining this cycle
    assign pc_ready = (!mem_req_valid || mem_req_ready) && (free_cnt >= pc_lines);

    assign pc_take = pc_valid && pc_ready;
    assign req_take = mem_req_valid && mem_req_ready;

    // the request's first line goes to the slot under the pointer
    assign mem_req_tag = alloc_ptr;

    // notice to the reorder buffer in the same cycle the host takes the request
    assign alloc_valid = req_take;
    assign alloc_tag = alloc_ptr;
    assign alloc_len = mem_req_len;
    assign alloc_id = req_id;
    assign alloc_last = req_last;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mem_req_valid <= 1'b0;
            alloc_ptr <= '0;
            free_cnt <= CNT_W'(ROB_DEPTH);
        end
        else
        begin
            if (pc_take)
                mem_req_valid <= 1'b1;
            else if (req_take)
                mem_req_valid <= 1'b0;

            // the pointer moves by the piece size once the request leaves
            if (req_take)
                alloc_ptr <= alloc_ptr + TAG_W'(mem_req_len) + TAG_W'(1);

            // credits are taken at acceptance and returned one per retired line
            free_cnt <= free_cnt - (pc_take ? pc_lines : '0) + CNT_W'(slot_free);
        end
    end

    always_ff @(posedge clk)
    begin
        if (pc_take)
        begin
            mem_req_addr <= pc_addr;
            mem_req_len <= pc_len;
            req_id <= pc_id;
            req_last <= pc_last;
        end
    end

endmodule

/* hw/read_rob.sv */
/* Reorder buffer for host read lines. Lines land in the slot given by their tag and
   leave in slot order toward the client, freeing one credit per retired line. */

`timescale 1ns/100ps

module read_rob
(
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              alloc_valid,
    input  logic [host_mem_pkg::TAG_W-1:0]    alloc_tag,
    input  logic [host_mem_pkg::LEN_W-1:0]    alloc_len,
    input  logic [host_mem_pkg::ID_W-1:0]     alloc_id,
    input  logic                              alloc_last,

    input  logic                              mem_rsp_valid,
    input  logic [host_mem_pkg::TAG_W-1:0]    mem_rsp_tag,
    input  logic [host_mem_pkg::DATA_W-1:0]   mem_rsp_data,

    output logic                              r_valid,
    input  logic                              r_ready,
    output logic [host_mem_pkg::DATA_W-1:0]   r_data,
    output logic [host_mem_pkg::ID_W-1:0]     r_id,
    output logic                              r_last,

    output logic                              slot_free
);

    import host_mem_pkg::*;

    // per slot payload that allocation and host responses write
    logic [DATA_W-1:0]      slot_data [ROB_DEPTH];
    logic [ID_W-1:0]        slot_id   [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   slot_last;

    // set when the host line has arrived, cleared when it is retired
    logic [ROB_DEPTH-1:0]   slot_filled;

    // oldest slot that has not yet gone to the client
    logic [TAG_W-1:0]       head;

    logic                   r_take;

    // the head slot is shown as soon as its line is present
    assign r_valid = slot_filled[head];
    assign r_data = slot_data[head];
    assign r_id = slot_id[head];
    assign r_last = slot_last[head];

    assign r_take = r_valid && r_ready;

    // each retired line hands one credit back to the allocator
    assign slot_free = r_take;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            slot_filled <= '0;
            head <= '0;
        end
        else
        begin
            if (r_take)
            begin
                slot_filled[head] <= 1'b0;
                head <= head + TAG_W'(1);
            end

            // a slot being retired is never the target of a new response,
            // since it is only reallocated after it is freed
            if (mem_rsp_valid)
                slot_filled[mem_rsp_tag] <= 1'b1;
        end
    end

    // record ID and burst end for every slot of a newly issued piece
    always_ff @(posedge clk)
    begin
        if (alloc_valid)
        begin
            for (int k = 0; k < MAX_PIECE_LINES; k++)
            begin
                if (LEN_W'(k) <= alloc_len)
                begin
                    slot_id[alloc_tag + TAG_W'(k)] <= alloc_id;
                    // only the final line of the final piece ends the client burst
                    slot_last[alloc_tag + TAG_W'(k)] <= alloc_last && (LEN_W'(k) == alloc_len);
                end
            end
        end
    end

    // host lines are stored by tag in whatever order they come back
    always_ff @(posedge clk)
    begin
        if (mem_rsp_valid)
            slot_data[mem_rsp_tag] <= mem_rsp_data;
    end

endmodule

/* hw/host_mem_rd_adapter.sv */
/* Read path adapter between an AXI-style client and a host memory port.
   Splits bursts, allocates reorder credits and returns lines to the client in order. */

`timescale 1ns/100ps

module host_mem_rd_adapter
(
    input  logic                              clk,
    input  logic                              rst_n,

    // client read requests
    input  logic                              ar_valid,
    output logic                              ar_ready,
    input  logic [host_mem_pkg::ADDR_W-1:0]   ar_addr,
    input  logic [host_mem_pkg::LEN_W-1:0]    ar_len,
    input  logic [host_mem_pkg::ID_W-1:0]     ar_id,

    // host requests, tagged with the first reorder slot
    output logic                              mem_req_valid,
    input  logic                              mem_req_ready,
    output logic [host_mem_pkg::ADDR_W-1:0]   mem_req_addr,
    output logic [host_mem_pkg::LEN_W-1:0]    mem_req_len,
    output logic [host_mem_pkg::TAG_W-1:0]    mem_req_tag,

    // host responses have no back-pressure
    input  logic                              mem_rsp_valid,
    input  logic [host_mem_pkg::TAG_W-1:0]    mem_rsp_tag,
    input  logic [host_mem_pkg::DATA_W-1:0]   mem_rsp_data,

    // client read data in request order
    output logic                              r_valid,
    input  logic                              r_ready,
    output logic [host_mem_pkg::DATA_W-1:0]   r_data,
    output logic [host_mem_pkg::ID_W-1:0]     r_id,
    output logic                              r_last
);

    import host_mem_pkg::*;

    // pieces from the splitter
    logic                pc_valid;
    logic                pc_ready;
    logic [ADDR_W-1:0]   pc_addr;
    logic [LEN_W-1:0]    pc_len;
    logic [ID_W-1:0]     pc_id;
    logic                pc_last;

    // allocation notice and credit return
    logic                alloc_valid;
    logic [TAG_W-1:0]    alloc_tag;
    logic [LEN_W-1:0]    alloc_len;
    logic [ID_W-1:0]     alloc_id;
    logic                alloc_last;
    logic                slot_free;

    burst_splitter splitter_i
    (
        .clk,
        .rst_n,
        .ar_valid,
        .ar_ready,
        .ar_addr,
        .ar_len,
        .ar_id,
        .pc_valid,
        .pc_ready,
        .pc_addr,
        .pc_len,
        .pc_id,
        .pc_last
    );

    rob_slot_alloc alloc_i
    (
        .clk,
        .rst_n,
        .pc_valid,
        .pc_ready,
        .pc_addr,
        .pc_len,
        .pc_id,
        .pc_last,
        .mem_req_valid,
        .mem_req_ready,
        .mem_req_addr,
        .mem_req_len,
        .mem_req_tag,
        .alloc_valid,
        .alloc_tag,
        .alloc_len,
        .alloc_id,
        .alloc_last,
        .slot_free
    );

    read_rob rob_i
    (
        .clk,
        .rst_n,
        .alloc_valid,
        .alloc_tag,
        .alloc_len,
        .alloc_id,
        .alloc_last,
        .mem_rsp_valid,
        .mem_rsp_tag,
        .mem_rsp_data,
        .r_valid,
        .r_ready,
        .r_data,
        .r_id,
        .r_last,
        .slot_free
    );

endmodule

/* tests/host_mem_model.sv */
/* Host memory model for the read adapter testbench. Takes requests with a random ready
   and answers each line after a random delay, in random order, with the line data rule. */

`timescale 1ns/100ps

module host_mem_model
(
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              mem_req_valid,
    output logic                              mem_req_ready,
    input  logic [host_mem_pkg::ADDR_W-1:0]   mem_req_addr,
    input  logic [host_mem_pkg::LEN_W-1:0]    mem_req_len,
    input  logic [host_mem_pkg::TAG_W-1:0]    mem_req_tag,

    output logic                              mem_rsp_valid,
    output logic [host_mem_pkg::TAG_W-1:0]    mem_rsp_tag,
    output logic [host_mem_pkg::DATA_W-1:0]   mem_rsp_data
);

    import host_mem_pkg::*;

    // at most this many lines wait for their answer
    localparam int PEND_MAX = 16;

    logic                pend_used  [PEND_MAX];
    logic [ADDR_W-1:0]   pend_addr  [PEND_MAX];
    logic [TAG_W-1:0]    pend_tag   [PEND_MAX];
    int                  pend_delay [PEND_MAX];

    initial
    begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_tag = '0;
        mem_rsp_data = '0;
    end

    always @(posedge clk)
    begin
        int due [$];
        int pick;
        int slot;
        int free_slots;
        if (!rst_n)
        begin
            for (int i = 0; i < PEND_MAX; i++)
                pend_used[i] = 1'b0;
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end
        else
        begin
            // age every waiting line and gather the ones whose delay ran out
            due.delete();
            for (int i = 0; i < PEND_MAX; i++)
            begin
                if (pend_used[i] && pend_delay[i] > 0)
                    pend_delay[i] = pend_delay[i] - 1;
                if (pend_used[i] && pend_delay[i] == 0)
                    due.push_back(i);
            end

            // any due line may go first, which scrambles the return order
            if (due.size() > 0)
            begin
                pick = due[$urandom % due.size()];
                pend_used[pick] = 1'b0;
                mem_rsp_valid <= 1'b1;
                mem_rsp_tag <= pend_tag[pick];
                mem_rsp_data <= pend_addr[pick] ^ 32'hC0DE0000;
            end
            else
            begin
                mem_rsp_valid <= 1'b0;
            end

            // every line of an accepted request waits on its own
            if (mem_req_valid && mem_req_ready)
            begin
                for (int k = 0; k <= int'(mem_req_len); k++)
                begin
                    slot = 0;
                    while (pend_used[slot])
                        slot++;
                    pend_used[slot] = 1'b1;
                    pend_addr[slot] = mem_req_addr + ADDR_W'(k);
                    pend_tag[slot] = mem_req_tag + TAG_W'(k);
                    pend_delay[slot] = 1 + int'($urandom % 8);
                end
            end

            // only take a request when the largest piece would still fit
            free_slots = 0;
            for (int i = 0; i < PEND_MAX; i++)
                if (!pend_used[i])
                    free_slots++;
            mem_req_ready <= (free_slots >= MAX_PIECE_LINES) && ($urandom % 4 != 0);
        end
    end

endmodule

/* tests/tb_host_mem.sv */
/* Directed testbench for the host memory read adapter. Drives client bursts against
   the host model and checks host requests, credit use and the in-order client data. */

`timescale 1ns/100ps

module tb_host_mem;

    import host_mem_pkg::*;

    // cycles any single wait may take before the run is declared stuck
    localparam int WAIT_LIMIT = 4000;

    logic                clk;
    logic                rst_n;
    logic                ar_valid;
    logic                ar_ready;
    logic [ADDR_W-1:0]   ar_addr;
    logic [LEN_W-1:0]    ar_len;
    logic [ID_W-1:0]     ar_id;
    logic                mem_req_valid;
    logic                mem_req_ready;
    logic [ADDR_W-1:0]   mem_req_addr;
    logic [LEN_W-1:0]    mem_req_len;
    logic [TAG_W-1:0]    mem_req_tag;
    logic                mem_rsp_valid;
    logic [TAG_W-1:0]    mem_rsp_tag;
    logic [DATA_W-1:0]   mem_rsp_data;
    logic                r_valid;
    logic                r_ready;
    logic [DATA_W-1:0]   r_data;
    logic [ID_W-1:0]     r_id;
    logic                r_last;

    // scoreboard of client bursts still owed data in issue order
    logic [ADDR_W-1:0]   exp_addr [$];
    logic [LEN_W-1:0]    exp_len [$];
    logic [ID_W-1:0]     exp_id [$];

    // next host address and lines still to be requested for each accepted burst
    logic [ADDR_W-1:0]   host_next [$];
    int                  host_left [$];

    // addresses of host requests that tests clear before counting them
    logic [ADDR_W-1:0]   req_log [$];

    // slots are handed out in ring order, so each request starts where the last one ended
    logic [TAG_W-1:0]    next_tag;

    // lines requested at the host but not yet retired to the client
    int                  outstanding;
    logic                random_ready;

    host_mem_rd_adapter dut_i
    (
        .clk,
        .rst_n,
        .ar_valid,
        .ar_ready,
        .ar_addr,
        .ar_len,
        .ar_id,
        .mem_req_valid,
        .mem_req_ready,
        .mem_req_addr,
        .mem_req_len,
        .mem_req_tag,
        .mem_rsp_valid,
        .mem_rsp_tag,
        .mem_rsp_data,
        .r_valid,
        .r_ready,
        .r_data,
        .r_id,
        .r_last
    );

    host_mem_model host_i
    (
        .clk,
        .rst_n,
        .mem_req_valid,
        .mem_req_ready,
        .mem_req_addr,
        .mem_req_len,
        .mem_req_tag,
        .mem_rsp_valid,
        .mem_rsp_tag,
        .mem_rsp_data
    );

    always #10 clk = ~clk;

    // the client either always takes data or stalls at random
    always @(posedge clk)
    begin
        if (random_ready)
            r_ready <= 1'($urandom % 2);
        else
            r_ready <= 1'b1;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    // the host side watch checks piece limits, contiguity, slot tags and the credit bound
    always @(posedge clk)
    begin
        int lines;
        if (rst_n)
        begin
            lines = 0;
            if (mem_req_valid && mem_req_ready)
            begin
                lines = int'(mem_req_len) + 1;
                req_log.push_back(mem_req_addr);
                if (host_left.size() == 0)
                    stop_with_error("a host request appeared with no client burst pending");
                else if (lines > MAX_PIECE_LINES || lines > host_left[0])
                    stop_with_error("a host request is longer than allowed");
                else if (int'(mem_req_addr % PAGE_LINES) + lines > PAGE_LINES)
                    stop_with_error("a host request crosses a page boundary");
                else
                begin
                    check_equal("mem_req_addr", mem_req_addr, host_next[0]);
                    check_equal("mem_req_tag", mem_req_tag, next_tag);
                    next_tag = next_tag + TAG_W'(lines);
                    host_next[0] = host_next[0] + ADDR_W'(lines);
                    host_left[0] = host_left[0] - lines;
                    if (host_left[0] == 0)
                    begin
                        void'(host_next.pop_front());
                        void'(host_left.pop_front());
                    end
                end
            end
            outstanding = outstanding + lines - ((r_valid && r_ready) ? 1 : 0);
            if (outstanding > ROB_DEPTH)
                stop_with_error("more lines are requested at the host than there are slots");
        end
    end

    task automatic send_burst(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                              input logic [ID_W-1:0] id);
        int waited;
        @(posedge clk);
        ar_valid <= 1'b1;
        ar_addr <= addr;
        ar_len <= len;
        ar_id <= id;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_with_error("the adapter accepted no read burst before the timeout");
        end
        while (!ar_ready);
        ar_valid <= 1'b0;
        exp_addr.push_back(addr);
        exp_len.push_back(len);
        exp_id.push_back(id);
        host_next.push_back(addr);
        host_left.push_back(int'(len) + 1);
    endtask

    task automatic wait_for_beat();
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_with_error("no read data arrived at the client before the timeout");
        end
        while (!(r_valid && r_ready));
    endtask

    // each beat must match the data rule for its line, its burst ID and the burst end
    task automatic collect_bursts(input int count);
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0] len;
        logic [ID_W-1:0] id;
        for (int b = 0; b < count; b++)
        begin
            wait_for_beat();
            if (exp_addr.size() == 0)
                stop_with_error("the client got read data with no burst outstanding");
            addr = exp_addr.pop_front();
            len = exp_len.pop_front();
            id = exp_id.pop_front();
            for (int beat = 0; beat <= int'(len); beat++)
            begin
                if (beat > 0)
                    wait_for_beat();
                check_equal("r_data", r_data, (addr + ADDR_W'(beat)) ^ 32'hC0DE0000);
                check_equal("r_id", r_id, id);
                check_equal("r_last", r_last, beat == int'(len));
            end
        end
    endtask

    task automatic single_burst_after_reset();
        check_equal("ar_ready", ar_ready, 1);
        check_equal("r_valid", r_valid, 0);
        check_equal("mem_req_valid", mem_req_valid, 0);
        fork
            send_burst(32'h0, 4'd2, 4'd5);
            collect_bursts(1);
        join
    endtask

    // from line 0x103 the pieces are 4, 4, 4, then 1 up to the page end, then 3
    task automatic split_long_burst();
        req_log.delete();
        fork
            send_burst(32'h103, 4'd15, 4'd9);
            collect_bursts(1);
        join
        check_equal("host request count", req_log.size(), 5);
    endtask

    task automatic split_at_page_end();
        req_log.delete();
        fork
            send_burst(32'd14, 4'd3, 4'd2);
            collect_bursts(1);
        join
        check_equal("host request count", req_log.size(), 2);
        check_equal("first mem_req_addr", req_log[0], 32'd14);
        check_equal("second mem_req_addr", req_log[1], 32'd16);
    endtask

    task automatic back_to_back_bursts();
        fork
            begin
                send_burst(32'h200, 4'd7, 4'd1);
                send_burst(32'h20C, 4'd0, 4'd2);
                send_burst(32'h30E, 4'd5, 4'd3);
                send_burst(32'h3F0, 4'd15, 4'd4);
                send_burst(32'h041, 4'd2, 4'd5);
            end
            collect_bursts(5);
        join
    endtask

    // long bursts and a stalling client use up all the reorder credits
    task automatic exhaust_credits();
        random_ready = 1'b1;
        fork
            for (int i = 0; i < 12; i++)
                send_burst(ADDR_W'($urandom % 1024), (i % 3 == 0) ? LEN_W'($urandom) : 4'd15,
                           ID_W'(i));
            collect_bursts(12);
        join
        random_ready = 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'h22154187));
        clk = 1'b0;
        rst_n = 1'b0;
        ar_valid = 1'b0;
        ar_addr = '0;
        ar_len = '0;
        ar_id = '0;
        r_ready = 1'b0;
        random_ready = 1'b0;
        outstanding = 0;
        next_tag = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        single_burst_after_reset();
        split_long_burst();
        split_at_page_end();
        back_to_back_bursts();
        exhaust_credits();
        // a few idle cycles so a stray host line would still be noticed
        repeat (20) @(posedge clk);
        check_equal("outstanding lines", outstanding, 0);
        check_equal("r_valid", r_valid, 0);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* files.f */
hw/host_mem_pkg.sv
hw/burst_splitter.sv
hw/rob_slot_alloc.sv
hw/read_rob.sv
hw/host_mem_rd_adapter.sv
tests/host_mem_model.sv
tests/tb_host_mem.sv

/* Bender.yml */
package:
  name: host_mem_rd_adapter

sources:
  - files:
      - hw/host_mem_pkg.sv
      - hw/burst_splitter.sv
      - hw/rob_slot_alloc.sv
      - hw/read_rob.sv
      - hw/host_mem_rd_adapter.sv
  - target: test
    files:
      - tests/host_mem_model.sv
      - tests/tb_host_mem.sv
